//--- compile.f
vga_pkg.sv
vga_h_counter.sv
vga_v_counter.sv
vga_sync.sv
vga_pattern_gen.sv
vga_top.sv
tb_vga.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_vga -o sim_vga
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_vga 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- tb_vga.sv
module tb_vga;

    localparam int FRAME_CYCLES = 88 * 23;  // Clocks per reduced frame
    localparam int MAX_TESTS    = 64;

    logic                  clk;
    logic                  rst_n;
    vga_pkg::pattern_sel_t pattern_sel;
    logic                  hsync_n;
    logic                  vsync_n;
    logic                  de;
    vga_pkg::chan_t        red;
    vga_pkg::chan_t        green;
    vga_pkg::chan_t        blue;
    vga_pkg::coord_t       pixel_x;
    vga_pkg::coord_t       pixel_y;

    byte t_kind [MAX_TESTS];        // C colour, S sync, W frame wrap
    int  t_val  [MAX_TESTS][6];     // Pattern, x, y, three expected values
    int  n_tests  = 0;
    int  n_failed = 0;              // Tests with at least one bad check
    int  errors   = 0;              // Failed checks
    int  cycles   = 0;
    int  limit    = 0;              // Set once the test count is known
    bit  test_ok;

    // Reduced mode of 88 clocks by 23 lines
    vga_top #(
        .H_SYNC (8), .H_BACK (8), .H_ACTIVE (64), .H_FRONT (8),
        .V_SYNC (2), .V_BACK (3), .V_ACTIVE (16), .V_FRONT (2)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .pattern_sel (pattern_sel),
        .hsync_n     (hsync_n),
        .vsync_n     (vsync_n),
        .de          (de),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // Period 4
    end

    // Watchdog allows a frame per test plus two spare
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d clock cycles", cycles);
        $display("Test failed");
        $finish;
    end

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        byte   kind;
        int    v [6];
        fd = $fopen("vga_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open vga_tests.txt, no tests were run");
            errors++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin    // Skip column notes
                    n = $sscanf(line, "%c %d %d %d %d %d %d",
                                kind, v[0], v[1], v[2], v[3], v[4], v[5]);
                    if (n == 7) begin
                        t_kind[n_tests] = kind;
                        t_val[n_tests]  = v;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_color(input string what, input vga_pkg::chan_t exp_r,
                               input vga_pkg::chan_t exp_g, input vga_pkg::chan_t exp_b);
        if (red !== exp_r || green !== exp_g || blue !== exp_b) begin
            $display("FAIL at %0t: %s colour %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, what, red, green, blue, exp_r, exp_g, exp_b);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_sync(input string what, input logic exp_hs, input logic exp_vs,
                              input logic exp_de);
        if (hsync_n !== exp_hs || vsync_n !== exp_vs || de !== exp_de) begin
            $display("FAIL at %0t: %s hsync_n/vsync_n/de %b%b%b, expected %b%b%b",
                     $time, what, hsync_n, vsync_n, de, exp_hs, exp_vs, exp_de);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_coord(input string what, input vga_pkg::coord_t exp_x,
                               input vga_pkg::coord_t exp_y);
        if (pixel_x !== exp_x || pixel_y !== exp_y) begin
            $display("FAIL at %0t: %s pixel %0d,%0d, expected %0d,%0d",
                     $time, what, pixel_x, pixel_y, exp_x, exp_y);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_period(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("FAIL at %0t: %s %0d cycles, expected %0d", $time, what, got, expected);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name);
        if (!test_ok) n_failed++;
        $display("%s: %s", name, test_ok ? "ok" : "mismatch");
    endtask

    // Steps pixel by pixel until the target shows on the outputs
    task automatic wait_for_pixel(input vga_pkg::coord_t x, input vga_pkg::coord_t y);
        @(posedge clk);
        #1;
        while (pixel_x !== x || pixel_y !== y) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_test(input int i);
        vga_pkg::coord_t x;
        vga_pkg::coord_t y;
        int              start;
        x = vga_pkg::coord_t'(t_val[i][1]);
        y = vga_pkg::coord_t'(t_val[i][2]);
        test_ok = 1'b1;
        pattern_sel = vga_pkg::pattern_sel_t'(t_val[i][0]);   // Used from the next edge
        wait_for_pixel(x, y);
        case (t_kind[i])
            "C": check_color("colour", vga_pkg::chan_t'(t_val[i][3]),
                             vga_pkg::chan_t'(t_val[i][4]), vga_pkg::chan_t'(t_val[i][5]));
            "S": check_sync("sync", t_val[i][3][0], t_val[i][4][0], t_val[i][5][0]);
            "W": begin
                start = cycles;
                wait_for_pixel(x, y);               // Same pixel one frame on
                check_period("frame period", cycles - start, t_val[i][3]);
            end
            default: begin
                $display("Test %0d has an unknown kind '%c'", i, t_kind[i]);
                errors++;
                test_ok = 1'b0;
            end
        endcase
        report_test($sformatf("test %0d %c pattern %0d at %0d,%0d",
                              i, t_kind[i], t_val[i][0], x, y));
    endtask

    initial begin
        rst_n       = 1'b0;
        pattern_sel = vga_pkg::PAT_WHITE;
        load_tests();
        limit = (n_tests + 2) * FRAME_CYCLES;
        repeat (3) @(posedge clk);
        #1;
        test_ok = 1'b1;
        check_sync("during reset", 1'b1, 1'b1, 1'b0);      // Syncs idle and no video
        check_color("during reset", 4'h0, 4'h0, 4'h0);
        report_test("reset hold");
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;                               // Low over five edges
        repeat (2) @(posedge clk);                  // Two stage pipeline
        #1;
        test_ok = 1'b1;
        check_coord("first pixel", 10'd0, 10'd0);
        check_sync("first pixel", 1'b0, 1'b0, 1'b0);
        report_test("reset release");
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        if (n_tests == 0) begin
            $display("No test vectors were read from vga_tests.txt");
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d check errors", n_tests + 2, n_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vga_h_counter.sv
module vga_h_counter #(
    parameter int H_TOTAL = 800  // Clocks per line, sync through front porch
) (
    input  logic            clk,
    input  logic            rst_n,
    output vga_pkg::coord_t h_count,
    output logic            line_end
);

    // Last column of the line
    localparam vga_pkg::coord_t H_LAST = vga_pkg::coord_t'(H_TOTAL - 1);

    // Column counter, wraps at end of line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_count <= '0;
        end else if (line_end) begin
            h_count <= '0;                      // Back to start of sync pulse
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    // Strobe on last column so the line counter steps on the same edge as the wrap
    assign line_end = (h_count == H_LAST);

    // Counter must never run past the line total
    a_h_count_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        h_count <= H_LAST
    ) else $error("h_count %0d beyond line total %0d", h_count, H_TOTAL);

endmodule

//--- vga_pattern_gen.sv
module vga_pattern_gen #(
    parameter int H_OFFSET = 144,  // First active column
    parameter int V_OFFSET = 35,   // First active line
    parameter int H_ACTIVE = 640
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  vga_pkg::pattern_sel_t pattern_sel,
    input  logic                  h_sync_n_in,
    input  logic                  v_sync_n_in,
    input  logic                  video_on,
    input  vga_pkg::coord_t       pixel_x,
    input  vga_pkg::coord_t       pixel_y,
    output logic                  hsync_n,
    output logic                  vsync_n,
    output logic                  de,
    output vga_pkg::chan_t        red,
    output vga_pkg::chan_t        green,
    output vga_pkg::chan_t        blue,
    output vga_pkg::coord_t       x_out,
    output vga_pkg::coord_t       y_out
);

    localparam vga_pkg::coord_t X_OFF = vga_pkg::coord_t'(H_OFFSET);
    localparam vga_pkg::coord_t Y_OFF = vga_pkg::coord_t'(V_OFFSET);
    localparam vga_pkg::coord_t BAR_W = vga_pkg::coord_t'(H_ACTIVE / 8);  // Columns per bar

    vga_pkg::coord_t ax;        // Column inside active area
    vga_pkg::coord_t ay;        // Line inside active area
    vga_pkg::coord_t bar_k;     // Bar index, 0 on the left
    logic [2:0]      bar_col;   // RGB bits of the current bar
    logic            chk_on;
    vga_pkg::chan_t  red_d;
    vga_pkg::chan_t  green_d;
    vga_pkg::chan_t  blue_d;

    // Only meaningful inside the window, masked by video_on below
    assign ax      = pixel_x - X_OFF;
    assign ay      = pixel_y - Y_OFF;
    assign bar_k   = ax / BAR_W;
    assign bar_col = 3'd7 - bar_k[2:0];     // White on the left, black on the right
    assign chk_on  = ax[4] ^ ay[4];

    // Colour for the current pixel
    always_comb begin
        red_d   = vga_pkg::CHAN_OFF;        // Blanked unless active
        green_d = vga_pkg::CHAN_OFF;
        blue_d  = vga_pkg::CHAN_OFF;
        if (video_on) begin
            case (vga_pkg::pattern_e'(pattern_sel))
                vga_pkg::PAT_BARS: begin
                    red_d   = {4{bar_col[2]}};
                    green_d = {4{bar_col[1]}};
                    blue_d  = {4{bar_col[0]}};
                end
                vga_pkg::PAT_CHECKER: begin
                    red_d   = {4{chk_on}};  // Black or white square
                    green_d = {4{chk_on}};
                    blue_d  = {4{chk_on}};
                end
                vga_pkg::PAT_GRADIENT: begin
                    red_d   = ax[5:2];      // Ramps every 4 columns
                    blue_d  = ay[3:0];      // Ramps every line
                end
                vga_pkg::PAT_WHITE: begin
                    red_d   = vga_pkg::CHAN_MAX;
                    green_d = vga_pkg::CHAN_MAX;
                    blue_d  = vga_pkg::CHAN_MAX;
                end
            endcase
        end
    end

    // Colour and delayed timing leave in the same stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_n <= 1'b1;
            vsync_n <= 1'b1;
            de      <= 1'b0;
            red     <= '0;
            green   <= '0;
            blue    <= '0;
            x_out   <= '0;
            y_out   <= '0;
        end else begin
            hsync_n <= h_sync_n_in;
            vsync_n <= v_sync_n_in;
            de      <= video_on;
            red     <= red_d;
            green   <= green_d;
            blue    <= blue_d;
            x_out   <= pixel_x;     // Keeps debug coords aligned with colour
            y_out   <= pixel_y;
        end
    end

    // Display sees black in every blanking interval
    a_blank_outside_de : assert property (
        @(posedge clk) disable iff (!rst_n)
        !de |-> (red == '0 && green == '0 && blue == '0)
    ) else $error("Colour not blanked at %0d,%0d", x_out, y_out);

endmodule

//--- vga_pkg.sv
package vga_pkg;

    // Pixel column or line number, wide enough for 800x525 modes
    typedef logic [9:0] coord_t;

    // One colour channel intensity
    typedef logic [3:0] chan_t;

    // Raw pattern select as it arrives on the top level pins
    typedef logic [1:0] pattern_sel_t;

    // Test images, encoded on the raw select value
    typedef enum pattern_sel_t {
        PAT_BARS     = 2'd0,  // Eight vertical colour bars
        PAT_CHECKER  = 2'd1,  // 16 pixel black/white squares
        PAT_GRADIENT = 2'd2,  // Red on column, blue on line
        PAT_WHITE    = 2'd3   // Solid full white
    } pattern_e;

    // Full and zero channel levels
    localparam chan_t CHAN_MAX = 4'hF;
    localparam chan_t CHAN_OFF = 4'h0;

endpackage

//--- vga_sync.sv
module vga_sync #(
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic            h_sync_n,   // Active low
    output logic            v_sync_n,   // Active low
    output logic            video_on,
    output vga_pkg::coord_t pixel_x,    // Debug coordinates
    output vga_pkg::coord_t pixel_y
);

    // Line and frame totals for the counters
    localparam int H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
    localparam int V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

    // Window edges in count units
    localparam vga_pkg::coord_t H_SYNC_END  = vga_pkg::coord_t'(H_SYNC);
    localparam vga_pkg::coord_t V_SYNC_END  = vga_pkg::coord_t'(V_SYNC);
    localparam vga_pkg::coord_t H_ACT_FIRST = vga_pkg::coord_t'(H_SYNC + H_BACK);
    localparam vga_pkg::coord_t H_ACT_LAST  = vga_pkg::coord_t'(H_SYNC + H_BACK + H_ACTIVE - 1);
    localparam vga_pkg::coord_t V_ACT_FIRST = vga_pkg::coord_t'(V_SYNC + V_BACK);
    localparam vga_pkg::coord_t V_ACT_LAST  = vga_pkg::coord_t'(V_SYNC + V_BACK + V_ACTIVE - 1);

    vga_pkg::coord_t h_count;
    vga_pkg::coord_t v_count;
    logic            line_end;  // Steps the line counter
    logic            h_active;
    logic            v_active;

    vga_h_counter #(.H_TOTAL(H_TOTAL)) u_h_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .h_count  (h_count),
        .line_end (line_end)
    );

    vga_v_counter #(.V_TOTAL(V_TOTAL)) u_v_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .line_end (line_end),
        .v_count  (v_count)
    );

    // Active video windows, inclusive on both edges
    assign h_active = (h_count >= H_ACT_FIRST) && (h_count <= H_ACT_LAST);
    assign v_active = (v_count >= V_ACT_FIRST) && (v_count <= V_ACT_LAST);

    // One register stage behind the raw counts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_sync_n <= 1'b1;           // Syncs idle high
            v_sync_n <= 1'b1;
            video_on <= 1'b0;
            pixel_x  <= '0;
            pixel_y  <= '0;
        end else begin
            h_sync_n <= !(h_count < H_SYNC_END);   // Low during retrace
            v_sync_n <= !(v_count < V_SYNC_END);
            video_on <= h_active && v_active;
            pixel_x  <= h_count;
            pixel_y  <= v_count;
        end
    end

    // Porches must keep the active window clear of both retraces
    a_no_video_in_sync : assert property (
        @(posedge clk) disable iff (!rst_n)
        video_on |-> (h_sync_n && v_sync_n)
    ) else $error("video_on high during sync at %0d,%0d", pixel_x, pixel_y);

endmodule

//--- vga_tests.txt
# kind pattern x y e1 e2 e3, C: e = red green blue, S: e = hsync_n vsync_n de
# W: e1 = clocks until x,y shows again. Lines in frame order
S 3 7 0 0 0 0
S 3 8 0 1 0 0
S 3 20 1 1 0 0
S 3 20 2 1 1 0
S 3 40 4 1 1 0
S 3 15 5 1 1 0
S 3 16 5 1 1 1
C 3 15 6 0 0 0
C 3 16 6 15 15 15
C 0 16 8 15 15 15
C 0 23 8 15 15 15
C 0 24 8 15 15 0
C 0 31 8 15 15 0
C 0 32 8 15 0 15
C 0 39 8 15 0 15
C 0 40 8 15 0 0
C 0 47 8 15 0 0
C 0 48 8 0 15 15
C 0 55 8 0 15 15
C 0 56 8 0 15 0
C 0 63 8 0 15 0
C 0 64 8 0 0 15
C 0 71 8 0 0 15
C 0 72 8 0 0 0
C 0 79 8 0 0 0
C 1 31 12 0 0 0
C 1 32 12 15 15 15
C 1 48 12 0 0 0
C 2 20 14 1 0 9
C 2 55 14 9 0 9
C 2 79 14 15 0 9
C 3 30 16 15 15 15
C 0 31 16 15 15 0
C 2 32 16 4 0 11
C 2 16 20 0 0 15
S 3 79 20 1 1 1
S 3 80 20 1 1 0
S 3 40 21 1 1 0
W 3 0 0 2024 0 0

//--- vga_top.sv
module vga_top #(
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10
) (
    input  logic                  clk,          // Pixel clock
    input  logic                  rst_n,
    input  vga_pkg::pattern_sel_t pattern_sel,
    output logic                  hsync_n,
    output logic                  vsync_n,
    output logic                  de,
    output vga_pkg::chan_t        red,
    output vga_pkg::chan_t        green,
    output vga_pkg::chan_t        blue,
    output vga_pkg::coord_t       pixel_x,
    output vga_pkg::coord_t       pixel_y
);

    // Start of the active area on each axis
    localparam int H_OFFSET = H_SYNC + H_BACK;
    localparam int V_OFFSET = V_SYNC + V_BACK;

    logic            s_h_sync_n;
    logic            s_v_sync_n;
    logic            s_video_on;
    vga_pkg::coord_t s_pixel_x;     // Sync stage coordinates
    vga_pkg::coord_t s_pixel_y;

    vga_sync #(
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT)
    ) u_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .h_sync_n (s_h_sync_n),
        .v_sync_n (s_v_sync_n),
        .video_on (s_video_on),
        .pixel_x  (s_pixel_x),
        .pixel_y  (s_pixel_y)
    );

    vga_pattern_gen #(
        .H_OFFSET (H_OFFSET),
        .V_OFFSET (V_OFFSET),
        .H_ACTIVE (H_ACTIVE)
    ) u_pattern_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .pattern_sel (pattern_sel),
        .h_sync_n_in (s_h_sync_n),
        .v_sync_n_in (s_v_sync_n),
        .video_on    (s_video_on),
        .pixel_x     (s_pixel_x),
        .pixel_y     (s_pixel_y),
        .hsync_n     (hsync_n),
        .vsync_n     (vsync_n),
        .de          (de),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .x_out       (pixel_x),     // Two clocks behind the counters
        .y_out       (pixel_y)
    );

endmodule

//--- vga_v_counter.sv
module vga_v_counter #(
    parameter int V_TOTAL = 525  // Lines per frame, sync through front porch
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            line_end,
    output vga_pkg::coord_t v_count
);

    // Last line of the frame
    localparam vga_pkg::coord_t V_LAST = vga_pkg::coord_t'(V_TOTAL - 1);

    // Line counter, only moves at the end of a line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_count <= '0;
        end else if (line_end) begin
            if (v_count == V_LAST) begin
                v_count <= '0;                  // Frame wrap
            end else begin
                v_count <= v_count + 10'd1;     // Next line
            end
        end
    end

    // Line count stays inside the frame
    a_v_count_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        v_count <= V_LAST
    ) else $error("v_count %0d beyond frame total %0d", v_count, V_TOTAL);

endmodule
